//--- axil_memory/axil_memory.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI-Lite memory slave on block RAM, with range check and shifted reads
// Connect the subordinate side of an axil_if, one read and one write in flight
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "axil_mem_defines.svh"

module axil_memory #(
    parameter int DEPTH_WORDS = `MEM_DEPTH_WORDS
) (
    input  logic aclk,
    input  logic aresetn,
    axil_if.subordinate bus
);

    localparam int IDX_W = $clog2(DEPTH_WORDS);

    // Write side holding registers
    logic                     aw_held;
    logic                     w_held;
    logic [`AXIL_ADDR_W-1:0]  aw_addr_q;
    logic [`AXIL_DATA_W-1:0]  w_data_q;
    logic [`AXIL_STRB_W-1:0]  w_strb_q;
    logic                     bvalid_q;
    axil_mem_pkg::axil_resp_t bresp_q;
    logic                     awready_q;
    logic                     wready_q;

    // Read side
    logic                     rvalid_q;
    logic                     arready_q;
    logic                     rd_err_q;
    logic [1:0]               rd_off_q;
    logic [`AXIL_DATA_W-1:0]  ram_rdata;

    logic aw_fire, w_fire, b_fire, wr_go, ar_fire, r_fire;
    logic aw_held_d, w_held_d, bvalid_d, rvalid_d;
    logic wr_ok, rd_ok;
    logic [`AXIL_ADDR_W-1:0] wr_off, rd_off;

    // True when the address falls inside the memory window
    function automatic logic in_range(input logic [`AXIL_ADDR_W-1:0] addr);
        logic [`AXIL_ADDR_W-1:0] off;
        off = addr - `MEM_BASE_ADDR;
        return (addr >= `MEM_BASE_ADDR) && ((off >> 2) < DEPTH_WORDS);
    endfunction

    assign aw_fire = bus.awvalid && awready_q;
    assign w_fire  = bus.wvalid && wready_q;
    assign b_fire  = bvalid_q && bus.bready;
    assign wr_go   = aw_held && w_held;  // Both halves of the write are in
    assign ar_fire = bus.arvalid && arready_q;
    assign r_fire  = rvalid_q && bus.rready;

    assign wr_off = aw_addr_q - `MEM_BASE_ADDR;
    assign rd_off = bus.araddr - `MEM_BASE_ADDR;
    assign wr_ok  = in_range(aw_addr_q);
    assign rd_ok  = in_range(bus.araddr);

    // Next state, so the registered readies track the hold flags exactly
    assign aw_held_d = wr_go ? 1'b0 : (aw_fire ? 1'b1 : aw_held);
    assign w_held_d  = wr_go ? 1'b0 : (w_fire ? 1'b1 : w_held);
    assign bvalid_d  = wr_go ? 1'b1 : (b_fire ? 1'b0 : bvalid_q);
    assign rvalid_d  = ar_fire ? 1'b1 : (r_fire ? 1'b0 : rvalid_q);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            aw_held   <= 1'b0;
            w_held    <= 1'b0;
            bvalid_q  <= 1'b0;
            awready_q <= 1'b0;
            wready_q  <= 1'b0;
            rvalid_q  <= 1'b0;
            arready_q <= 1'b0;
        end else begin
            aw_held   <= aw_held_d;
            w_held    <= w_held_d;
            bvalid_q  <= bvalid_d;
            awready_q <= !aw_held_d && !bvalid_d;  // No new write until B is taken
            wready_q  <= !w_held_d && !bvalid_d;
            rvalid_q  <= rvalid_d;
            arready_q <= !rvalid_d;  // A pending read is the same as rvalid here
        end
    end

    always_ff @(posedge aclk) begin
        if (aw_fire) begin
            aw_addr_q <= bus.awaddr;
        end
        if (w_fire) begin
            w_data_q <= bus.wdata;
            w_strb_q <= bus.wstrb;
        end
        if (wr_go) begin
            bresp_q <= wr_ok ? axil_mem_pkg::RESP_OKAY : axil_mem_pkg::RESP_SLVERR;
        end
        if (ar_fire) begin
            rd_err_q <= !rd_ok;
            rd_off_q <= rd_off[1:0];
        end
    end

    byte_lane_ram #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) ram_i (
        .aclk  (aclk),
        .we    (wr_go && wr_ok),  // Out of range writes leave memory untouched
        .be    (w_strb_q),
        .waddr (wr_off[2 +: IDX_W]),
        .wdata (w_data_q),
        .re    (ar_fire && rd_ok),
        .raddr (rd_off[2 +: IDX_W]),
        .rdata (ram_rdata)
    );

    assign bus.awready = awready_q;
    assign bus.wready  = wready_q;
    assign bus.bvalid  = bvalid_q;
    assign bus.bresp   = bresp_q;
    assign bus.arready = arready_q;
    assign bus.rvalid  = rvalid_q;

    // Word is shifted down by the byte offset and zero filled from the top
    assign bus.rdata = rd_err_q ? '0 : (ram_rdata >> {rd_off_q, 3'b000});
    assign bus.rresp = rd_err_q ? axil_mem_pkg::RESP_SLVERR : axil_mem_pkg::RESP_OKAY;

    rvalid_stable_a: assert property (@(posedge aclk) disable iff (!aresetn)
        rvalid_q && !bus.rready |=>
            rvalid_q && $stable(bus.rdata) && $stable(bus.rresp));

    bvalid_stable_a: assert property (@(posedge aclk) disable iff (!aresetn)
        bvalid_q && !bus.bready |=> bvalid_q && $stable(bus.bresp));

endmodule

//--- axil_memory/byte_lane_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Block RAM with byte write enables and a registered read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "axil_mem_defines.svh"

module byte_lane_ram #(
    parameter int DEPTH_WORDS = `MEM_DEPTH_WORDS
) (
    input  logic                                  aclk,
    input  logic                                  we,
    input  logic [`AXIL_STRB_W-1:0]               be,
    input  logic [$clog2(DEPTH_WORDS)-1:0]        waddr,
    input  logic [`AXIL_DATA_W-1:0]               wdata,
    input  logic                                  re,
    input  logic [$clog2(DEPTH_WORDS)-1:0]        raddr,
    output logic [`AXIL_DATA_W-1:0]               rdata
);

    logic [`AXIL_DATA_W-1:0] mem [DEPTH_WORDS];

    // Memory comes up cleared, there is no firmware image
    initial begin
        for (int i = 0; i < DEPTH_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge aclk) begin
        if (we) begin
            for (int b = 0; b < `AXIL_STRB_W; b++) begin
                if (be[b]) begin
                    mem[waddr][8*b +: 8] <= wdata[8*b +: 8];  // Only the strobed lanes
                end
            end
        end
    end

    // Output register holds its word until the next read enable
    always_ff @(posedge aclk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

//--- common/axil_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI-Lite bundle with manager and subordinate views, used inside the design
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "axil_mem_defines.svh"

interface axil_if;

    logic [`AXIL_ADDR_W-1:0]  awaddr;
    logic                     awvalid;
    logic                     awready;

    logic [`AXIL_DATA_W-1:0]  wdata;
    logic [`AXIL_STRB_W-1:0]  wstrb;
    logic                     wvalid;
    logic                     wready;

    axil_mem_pkg::axil_resp_t bresp;
    logic                     bvalid;
    logic                     bready;

    logic [`AXIL_ADDR_W-1:0]  araddr;
    logic                     arvalid;
    logic                     arready;

    logic [`AXIL_DATA_W-1:0]  rdata;
    axil_mem_pkg::axil_resp_t rresp;
    logic                     rvalid;
    logic                     rready;

    modport manager (
        output awaddr, awvalid, input awready,
        output wdata, wstrb, wvalid, input wready,
        input bresp, bvalid, output bready,
        output araddr, arvalid, input arready,
        input rdata, rresp, rvalid, output rready
    );

    modport subordinate (
        input awaddr, awvalid, output awready,
        input wdata, wstrb, wvalid, output wready,
        output bresp, bvalid, input bready,
        input araddr, arvalid, output arready,
        output rdata, rresp, rvalid, input rready
    );

endinterface

//--- common/axil_mem_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus widths and memory map of the shared AXI-Lite memory
// Include wherever a width, the base address or the depth is needed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef AXIL_MEM_DEFINES_SVH
`define AXIL_MEM_DEFINES_SVH

// AXI-Lite address and data widths
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32

// One strobe bit per data byte
`define AXIL_STRB_W (`AXIL_DATA_W / 8)

// Byte address of the first memory word
`define MEM_BASE_ADDR 32'h0000_1000

// Memory size in 32-bit words
`define MEM_DEPTH_WORDS 1024

`endif

//--- common/axil_mem_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the AXI-Lite memory subsystem, used by scoped name
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package axil_mem_pkg;

    // AXI response codes, only the two this memory returns
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_t;

    // Read arbiter FSM states
    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,  // Waiting for a request, grant is combinational
        ARB_ADDR = 2'd1,  // Grant held, memory not yet ready for AR
        ARB_DATA = 2'd2   // AR accepted, waiting for the R handshake
    } arb_state_t;

    // Which manager owns the shared read channel
    typedef enum logic {
        OWNER_FETCH = 1'b0,
        OWNER_DATA  = 1'b1
    } rd_owner_t;

endpackage

//--- compile.f
+incdir+common
common/axil_mem_pkg.sv
common/axil_if.sv
axil_memory/byte_lane_ram.sv
axil_memory/axil_memory.sv
rtl/axil_read_arbiter.sv
rtl/axil_mem_top.sv
test/tb_axil_mem.sv

//--- rtl/axil_mem_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared AXI-Lite memory with a read-only fetch port and a read/write data port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "axil_mem_defines.svh"

module axil_mem_top (
    input  logic                    aclk,
    input  logic                    aresetn,

    // Fetch manager, read channels only
    input  logic [`AXIL_ADDR_W-1:0] f_araddr,
    input  logic                    f_arvalid,
    output logic                    f_arready,
    output logic [`AXIL_DATA_W-1:0] f_rdata,
    output logic [1:0]              f_rresp,
    output logic                    f_rvalid,
    input  logic                    f_rready,

    // Data manager
    input  logic [`AXIL_ADDR_W-1:0] d_awaddr,
    input  logic                    d_awvalid,
    output logic                    d_awready,
    input  logic [`AXIL_DATA_W-1:0] d_wdata,
    input  logic [`AXIL_STRB_W-1:0] d_wstrb,
    input  logic                    d_wvalid,
    output logic                    d_wready,
    output logic [1:0]              d_bresp,
    output logic                    d_bvalid,
    input  logic                    d_bready,
    input  logic [`AXIL_ADDR_W-1:0] d_araddr,
    input  logic                    d_arvalid,
    output logic                    d_arready,
    output logic [`AXIL_DATA_W-1:0] d_rdata,
    output logic [1:0]              d_rresp,
    output logic                    d_rvalid,
    input  logic                    d_rready
);

    axil_if mem_bus ();

    // Only the data port writes, so its write channels go straight to memory
    assign mem_bus.awaddr  = d_awaddr;
    assign mem_bus.awvalid = d_awvalid;
    assign d_awready       = mem_bus.awready;
    assign mem_bus.wdata   = d_wdata;
    assign mem_bus.wstrb   = d_wstrb;
    assign mem_bus.wvalid  = d_wvalid;
    assign d_wready        = mem_bus.wready;
    assign d_bresp         = mem_bus.bresp;
    assign d_bvalid        = mem_bus.bvalid;
    assign mem_bus.bready  = d_bready;

    axil_read_arbiter read_arb_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .f_araddr  (f_araddr),
        .f_arvalid (f_arvalid),
        .f_arready (f_arready),
        .f_rdata   (f_rdata),
        .f_rresp   (f_rresp),
        .f_rvalid  (f_rvalid),
        .f_rready  (f_rready),
        .d_araddr  (d_araddr),
        .d_arvalid (d_arvalid),
        .d_arready (d_arready),
        .d_rdata   (d_rdata),
        .d_rresp   (d_rresp),
        .d_rvalid  (d_rvalid),
        .d_rready  (d_rready),
        .mem       (mem_bus)
    );

    axil_memory #(
        .DEPTH_WORDS (`MEM_DEPTH_WORDS)
    ) memory_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .bus     (mem_bus)
    );

endmodule

//--- rtl/axil_read_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin arbiter that shares one AXI-Lite read channel between two managers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "axil_mem_defines.svh"

module axil_read_arbiter (
    input  logic                    aclk,
    input  logic                    aresetn,

    input  logic [`AXIL_ADDR_W-1:0] f_araddr,
    input  logic                    f_arvalid,
    output logic                    f_arready,
    output logic [`AXIL_DATA_W-1:0] f_rdata,
    output logic [1:0]              f_rresp,
    output logic                    f_rvalid,
    input  logic                    f_rready,

    input  logic [`AXIL_ADDR_W-1:0] d_araddr,
    input  logic                    d_arvalid,
    output logic                    d_arready,
    output logic [`AXIL_DATA_W-1:0] d_rdata,
    output logic [1:0]              d_rresp,
    output logic                    d_rvalid,
    input  logic                    d_rready,

    axil_if.manager mem
);

    axil_mem_pkg::arb_state_t state;
    axil_mem_pkg::rd_owner_t  owner_q;  // Grant held past ARB_IDLE
    axil_mem_pkg::rd_owner_t  turn;     // Who wins when both ask
    axil_mem_pkg::rd_owner_t  pick;
    axil_mem_pkg::rd_owner_t  owner;
    logic any_req;
    logic addressing;
    logic own_fetch;

    assign any_req = f_arvalid || d_arvalid;

    always_comb begin
        if (f_arvalid && d_arvalid) begin
            pick = turn;
        end else if (d_arvalid) begin
            pick = axil_mem_pkg::OWNER_DATA;
        end else begin
            pick = axil_mem_pkg::OWNER_FETCH;
        end
    end

    // In idle the grant follows the requests directly and is held after that
    assign owner      = (state == axil_mem_pkg::ARB_IDLE) ? pick : owner_q;
    assign own_fetch  = (owner == axil_mem_pkg::OWNER_FETCH);
    assign addressing = (state != axil_mem_pkg::ARB_DATA);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state   <= axil_mem_pkg::ARB_IDLE;
            owner_q <= axil_mem_pkg::OWNER_FETCH;
            turn    <= axil_mem_pkg::OWNER_FETCH;
        end else begin
            case (state)
                axil_mem_pkg::ARB_IDLE: begin
                    if (any_req) begin
                        owner_q <= pick;
                        state   <= mem.arready ? axil_mem_pkg::ARB_DATA
                                               : axil_mem_pkg::ARB_ADDR;
                    end
                end
                axil_mem_pkg::ARB_ADDR: begin
                    if (mem.arvalid && mem.arready) begin
                        state <= axil_mem_pkg::ARB_DATA;
                    end
                end
                axil_mem_pkg::ARB_DATA: begin
                    if (mem.rvalid && mem.rready) begin
                        state <= axil_mem_pkg::ARB_IDLE;
                        // The manager just served goes to the back of the line
                        turn  <= (owner_q == axil_mem_pkg::OWNER_FETCH)
                                 ? axil_mem_pkg::OWNER_DATA : axil_mem_pkg::OWNER_FETCH;
                    end
                end
                default: state <= axil_mem_pkg::ARB_IDLE;
            endcase
        end
    end

    assign mem.araddr  = own_fetch ? f_araddr : d_araddr;
    assign mem.arvalid = addressing && (own_fetch ? f_arvalid : d_arvalid);
    assign f_arready   = addressing && own_fetch && mem.arready;
    assign d_arready   = addressing && !own_fetch && mem.arready;

    // R goes back only to the manager that holds the grant
    assign f_rvalid  = !addressing && (owner_q == axil_mem_pkg::OWNER_FETCH) && mem.rvalid;
    assign d_rvalid  = !addressing && (owner_q == axil_mem_pkg::OWNER_DATA) && mem.rvalid;
    assign mem.rready = !addressing &&
                        ((owner_q == axil_mem_pkg::OWNER_FETCH) ? f_rready : d_rready);
    assign f_rdata = mem.rdata;
    assign f_rresp = mem.rresp;
    assign d_rdata = mem.rdata;
    assign d_rresp = mem.rresp;

    // An accepted address moves the FSM to ARB_DATA with the same owner
    owner_held_a: assert property (@(posedge aclk) disable iff (!aresetn)
        mem.arvalid && mem.arready |=>
            (state == axil_mem_pkg::ARB_DATA) && (owner == $past(owner)));

    // Each memory response reaches exactly one manager
    one_rvalid_a: assert property (@(posedge aclk) disable iff (!aresetn)
        mem.rvalid |-> (f_rvalid ^ d_rvalid));

endmodule

//--- test/tb_axil_mem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-checking testbench for the shared AXI-Lite memory
// Runs round trips, strobes, unaligned and out-of-range access, arbitration
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "axil_mem_defines.svh"

module tb_axil_mem;

    localparam int TXN_TOTAL   = 48 + 32 + 12 + 12 + 32 + 24;  // Sum over all six tests
    localparam int CYCLE_LIMIT = 40 * TXN_TOTAL + 200;

    logic aclk = 1'b0;
    logic aresetn;
    logic [`AXIL_ADDR_W-1:0] f_araddr, d_awaddr, d_araddr;
    logic f_arvalid, f_arready, f_rvalid, f_rready;
    logic [`AXIL_DATA_W-1:0] f_rdata, d_wdata, d_rdata;
    logic [1:0] f_rresp, d_bresp, d_rresp;
    logic [`AXIL_STRB_W-1:0] d_wstrb;
    logic d_awvalid, d_awready, d_wvalid, d_wready, d_bvalid, d_bready;
    logic d_arvalid, d_arready, d_rvalid, d_rready;

    logic [`AXIL_DATA_W-1:0] model [`MEM_DEPTH_WORDS];  // Expected memory contents
    logic [33:0] f_exp [$];  // {rresp, rdata} per outstanding read
    logic [33:0] d_exp [$];
    axil_mem_pkg::axil_resp_t b_exp [$];
    logic [31:0] wr_addrs [$];
    logic [31:0] rng = 32'h4d3a9d0c;
    logic [31:0] rdy_rng = ~32'h4d3a9d0c;
    int errors = 0, checks = 0, mark_errors = 0, mark_checks = 0, cycles = 0;
    int f_ar_cnt = 0, d_ar_cnt = 0, f_r_cnt = 0, d_r_cnt = 0;
    logic bp_mode = 1'b0, alt_check = 1'b0, r_seen = 1'b0;
    axil_mem_pkg::rd_owner_t last_port;
    logic r_wait [2] = '{1'b0, 1'b0};
    logic [31:0] r_hold_data [2];
    logic [1:0] r_hold_resp [2];
    logic b_wait = 1'b0;
    logic [1:0] b_hold_resp;

    axil_mem_top dut_i (.*);

    always #2 aclk = ~aclk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] draw_stim();
        rng = lcg_next(rng);
        return rng;
    endfunction

    function automatic logic [31:0] pick_addr();
        return `MEM_BASE_ADDR + ((draw_stim() >> 8) % `MEM_DEPTH_WORDS) * 4;
    endfunction

    function automatic logic in_window(input logic [31:0] addr);
        return (addr >= `MEM_BASE_ADDR) && ((addr - `MEM_BASE_ADDR) < `MEM_DEPTH_WORDS * 4);
    endfunction

    // Expected {rresp, rdata}, the word shifted down by its byte offset
    function automatic logic [33:0] ref_read(input logic [31:0] addr);
        logic [31:0] off;
        logic [31:0] word;
        off = addr - `MEM_BASE_ADDR;
        if (!in_window(addr)) begin
            return {axil_mem_pkg::RESP_SLVERR, 32'h0};
        end
        word = model[off >> 2];
        return {axil_mem_pkg::RESP_OKAY, word >> (8 * off[1:0])};
    endfunction

    function automatic axil_mem_pkg::axil_resp_t model_write(input logic [31:0] addr,
            input logic [31:0] data, input logic [3:0] strb);
        logic [31:0] idx;
        if (!in_window(addr)) begin
            return axil_mem_pkg::RESP_SLVERR;  // Memory keeps its old contents
        end
        idx = (addr - `MEM_BASE_ADDR) >> 2;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                model[idx][8*b +: 8] = data[8*b +: 8];
            end
        end
        return axil_mem_pkg::RESP_OKAY;
    endfunction

    task automatic issue_write(input logic [31:0] addr, input logic [31:0] data,
            input logic [3:0] strb);
        logic aw_done;
        logic w_done;
        aw_done = 1'b0;
        w_done = 1'b0;
        b_exp.push_back(model_write(addr, data, strb));
        @(negedge aclk);
        d_awaddr = addr;
        d_awvalid = 1'b1;
        d_wdata = data;
        d_wstrb = strb;
        d_wvalid = 1'b1;
        while (!(aw_done && w_done)) begin
            @(posedge aclk);
            aw_done = aw_done || (d_awvalid && d_awready);
            w_done = w_done || (d_wvalid && d_wready);
            @(negedge aclk);
            d_awvalid = d_awvalid && !aw_done;
            d_wvalid = d_wvalid && !w_done;
        end
        do @(posedge aclk); while (!(d_bvalid && d_bready));
    endtask

    task automatic issue_read(input axil_mem_pkg::rd_owner_t port, input logic [31:0] addr);
        logic fetch;
        logic done;
        fetch = (port == axil_mem_pkg::OWNER_FETCH);
        if (fetch) f_exp.push_back(ref_read(addr));
        else d_exp.push_back(ref_read(addr));
        @(negedge aclk);
        if (fetch) begin
            f_araddr = addr;
            f_arvalid = 1'b1;
        end else begin
            d_araddr = addr;
            d_arvalid = 1'b1;
        end
        do begin
            @(posedge aclk);
            done = fetch ? f_arready : d_arready;
        end while (!done);
        @(negedge aclk);
        if (fetch) f_arvalid = 1'b0;
        else d_arvalid = 1'b0;
        do begin
            @(posedge aclk);
            done = fetch ? (f_rvalid && f_rready) : (d_rvalid && d_rready);
        end while (!done);
    endtask

    task automatic check_read(input axil_mem_pkg::rd_owner_t port, input logic [31:0] rd,
            input logic [1:0] rr);
        logic [33:0] want;
        logic empty;
        empty = (port == axil_mem_pkg::OWNER_FETCH) ? (f_exp.size() == 0) : (d_exp.size() == 0);
        assert (!empty) else begin
            $display("R response on %s port with no read outstanding", port.name());
            errors++;
        end
        if (!empty) begin
            want = (port == axil_mem_pkg::OWNER_FETCH) ? f_exp.pop_front() : d_exp.pop_front();
            checks++;
            assert (rd == want[31:0] && rr == want[33:32]) else begin
                $display("mismatch at %0t: %s read got %h/%0d, expected %h/%0d", $time,
                         port.name(), rd, rr, want[31:0], want[33:32]);
                errors++;
            end
        end
        // Round robin means no port wins twice while the other waits
        if (alt_check && r_seen) begin
            assert (port != last_port) else begin
                $display("read handshakes did not alternate, %s served twice", port.name());
                errors++;
            end
        end
        r_seen = 1'b1;
        last_port = port;
    endtask

    task automatic check_r_hold(input int p, input logic rv, input logic rdy,
            input logic [31:0] rd, input logic [1:0] rr);
        if (r_wait[p]) begin
            assert (rv && rd == r_hold_data[p] && rr == r_hold_resp[p]) else begin
                $display("mismatch at %0t: R on port %0d changed before rready", $time, p);
                errors++;
            end
        end
        r_wait[p] = rv && !rdy;
        r_hold_data[p] = rd;
        r_hold_resp[p] = rr;
    endtask

    task automatic end_test(input string name);
        $display("%-18s %0d checks, %0d errors", name, checks - mark_checks, errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    // Comparing process, sampled at the rising edge where every input is settled
    always @(posedge aclk) begin
        if (aresetn) begin
            f_ar_cnt += (f_arvalid && f_arready);
            d_ar_cnt += (d_arvalid && d_arready);
            check_r_hold(0, f_rvalid, f_rready, f_rdata, f_rresp);
            check_r_hold(1, d_rvalid, d_rready, d_rdata, d_rresp);
            if (b_wait) begin
                assert (d_bvalid && d_bresp == b_hold_resp) else begin
                    $display("mismatch at %0t: B changed before bready", $time);
                    errors++;
                end
            end
            b_wait = d_bvalid && !d_bready;
            b_hold_resp = d_bresp;
            if (f_rvalid && f_rready) begin
                f_r_cnt++;
                check_read(axil_mem_pkg::OWNER_FETCH, f_rdata, f_rresp);
            end
            if (d_rvalid && d_rready) begin
                d_r_cnt++;
                check_read(axil_mem_pkg::OWNER_DATA, d_rdata, d_rresp);
            end
            if (d_bvalid && d_bready) begin
                checks++;
                assert (b_exp.size() > 0 && d_bresp == b_exp.pop_front()) else begin
                    $display("mismatch at %0t: unexpected bresp %0d", $time, d_bresp);
                    errors++;
                end
            end
        end
    end

    // Ready patterns, random stretches low while back-pressure is on
    always @(negedge aclk) begin
        rdy_rng = lcg_next(rdy_rng);
        f_rready = !bp_mode || (rdy_rng[31:29] > 3'd3);
        d_rready = !bp_mode || (rdy_rng[27:25] > 3'd3);
        d_bready = !bp_mode || (rdy_rng[23:21] > 3'd3);
    end

    always @(posedge aclk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        logic [31:0] a;
        foreach (model[i]) model[i] = '0;
        aresetn = 1'b0;
        {f_araddr, f_arvalid, f_rready, d_awaddr, d_awvalid, d_wdata, d_wstrb} = '0;
        {d_wvalid, d_bready, d_araddr, d_arvalid, d_rready} = '0;
        repeat (5) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;

        for (int i = 0; i < 16; i++) begin
            wr_addrs.push_back(pick_addr());
            issue_write(wr_addrs[i], draw_stim(), 4'hf);
        end
        foreach (wr_addrs[i]) begin
            issue_read(axil_mem_pkg::OWNER_FETCH, wr_addrs[i]);
            issue_read(axil_mem_pkg::OWNER_DATA, wr_addrs[i]);
        end
        end_test("full_word");

        for (int i = 0; i < 16; i++) begin
            a = wr_addrs[draw_stim() % 16];
            issue_write(a, draw_stim(), draw_stim() >> 28);
            issue_read(axil_mem_pkg::OWNER_DATA, a);
        end
        end_test("byte_strobes");

        for (int i = 0; i < 12; i++) begin
            a = wr_addrs[draw_stim() % 16] + 1 + (draw_stim() % 3);
            issue_read(axil_mem_pkg::rd_owner_t'(i[0]), a);
        end
        end_test("unaligned_reads");

        for (int i = 0; i < 4; i++) begin
            // Two below the base, two past the end of the window
            a = (i < 2) ? `MEM_BASE_ADDR - 4 * (1 + draw_stim() % 64)
                        : `MEM_BASE_ADDR + `MEM_DEPTH_WORDS * 4 + 4 * (draw_stim() % 64);
            issue_write(a, draw_stim(), 4'hf);
            issue_read(axil_mem_pkg::OWNER_DATA,
                       `MEM_BASE_ADDR + ((a - `MEM_BASE_ADDR) & (`MEM_DEPTH_WORDS * 4 - 1)));
            issue_read(axil_mem_pkg::OWNER_FETCH, a);
        end
        end_test("out_of_range");

        alt_check = 1'b1;
        r_seen = 1'b0;
        fork
            for (int i = 0; i < 16; i++) issue_read(axil_mem_pkg::OWNER_FETCH, pick_addr());
            for (int i = 0; i < 16; i++) issue_read(axil_mem_pkg::OWNER_DATA, pick_addr());
        join
        alt_check = 1'b0;
        end_test("arbitration");

        bp_mode = 1'b1;
        for (int i = 0; i < 8; i++) begin
            issue_write(wr_addrs[i], draw_stim(), draw_stim() >> 28);
        end
        fork
            for (int i = 0; i < 8; i++) issue_read(axil_mem_pkg::OWNER_FETCH, wr_addrs[i]);
            for (int i = 0; i < 8; i++) issue_read(axil_mem_pkg::OWNER_DATA, wr_addrs[i + 8]);
        join
        bp_mode = 1'b0;
        repeat (4) @(posedge aclk);
        assert (f_ar_cnt == f_r_cnt && d_ar_cnt == d_r_cnt) else begin
            $display("read lost or duplicated: fetch %0d AR/%0d R, data %0d AR/%0d R",
                     f_ar_cnt, f_r_cnt, d_ar_cnt, d_r_cnt);
            errors++;
        end
        assert (f_exp.size() == 0 && d_exp.size() == 0 && b_exp.size() == 0) else begin
            $display("responses still missing at the end of the run");
            errors++;
        end
        end_test("back_pressure");

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
